// File: dv/tb_scratchpad_checks.svh
// Reference model and typed compare tasks for the scratchpad testbench.
// Included inside the testbench module, which imports mem_pkg.

`ifndef TB_SCRATCHPAD_CHECKS_SVH
`define TB_SCRATCHPAD_CHECKS_SVH

// shadow copy of both banks, indexed by the full scratchpad address
word_t shadow_mem [1 << SP_AW];

int err_count = 0;

// update the shadow copy for a write the DUT accepts
function automatic void model_write(input sp_addr_t addr, input word_t data);
   shadow_mem[addr] = data;
endfunction

// expected read result, the last word written to that address
function automatic word_t expected_word(input sp_addr_t addr);
   return shadow_mem[addr];
endfunction

task automatic check_word(input string name, input word_t exp, input word_t act);
   if (act !== exp)
   begin
      $display("** Error at time %0t: %s expected %h, got %h", $time, name, exp, act);
      err_count++;
   end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
   if (act !== exp)
   begin
      $display("** Error at time %0t: %s expected %b, got %b", $time, name, exp, act);
      err_count++;
   end
endtask

`endif

// File: dv/tb_scratchpad.sv
// Testbench for the two-bank scratchpad. Drives reads and writes into
// scratchpad_top and checks every read pulse against a shadow model.

`timescale 1ns/10ps

module tb_scratchpad
   import mem_pkg::*;
;
   logic    clk_i;
   logic    reset_i;
   sp_req_t req_i;
   word_t   rdata_o;
   logic    rvalid_o;

   int      seed = 15406;
   int      req_count = 0;
   int      read_count = 0;
   int      pulse_count = 0;
   int      wd_cycles = 0;

   // monitor state
   word_t   exp_q [$];
   word_t   last_exp;
   logic    prev_rd;

   `include "tb_scratchpad_checks.svh"

   scratchpad_top u_scratchpad_top
   (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .req_i    (req_i),
      .rdata_o  (rdata_o),
      .rvalid_o (rvalid_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   // fill data depends on every address bit
   function automatic word_t fill_pattern(input sp_addr_t a);
      return {a[7:0], ~a, 15'h3c5a};
   endfunction

   task automatic issue(input logic is_write, input sp_addr_t addr, input word_t data);
      sp_req_t r;
      r.v    = 1'b1;
      r.w    = is_write;
      r.addr = addr;
      r.data = data;
      @(posedge clk_i);
      req_i <= r;
      req_count++;
   endtask

   task automatic idle();
      @(posedge clk_i);
      req_i <= '0;
   endtask

   // drop the request and wait for all reads in flight to return
   task automatic drain();
      int waited;
      waited = 0;
      idle();
      while (exp_q.size() != 0 && waited < 8)
      begin
         @(posedge clk_i);
         waited++;
      end
      if (exp_q.size() != 0)
      begin
         $display("read data still missing after %0d idle cycles", waited);
         err_count++;
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      $display("test %-12s %s (%0d errors)", name,
               (err_count == errs_before) ? "passed" : "FAILED", err_count - errs_before);
   endtask

   // sample between edges, where every DUT output is settled
   always @(negedge clk_i)
   begin
      if (reset_i)
      begin
         prev_rd  = 1'b0;
         last_exp = '0;
         exp_q.delete();
      end
      else
      begin
         check_bit("rvalid_o", prev_rd, rvalid_o);
         if (rvalid_o === 1'b1)
         begin
            pulse_count++;
            if (exp_q.size() == 0)
            begin
               $display("rvalid_o pulsed at time %0t with no read outstanding", $time);
               err_count++;
            end
            else
            begin
               last_exp = exp_q.pop_front();
            end
         end
         // between pulses this is the hold rule
         check_word("rdata_o", last_exp, rdata_o);
         prev_rd = 1'b0;
         if (req_i.v === 1'b1)
         begin
            if (req_i.w)
            begin
               model_write(req_i.addr, req_i.data);
            end
            else
            begin
               exp_q.push_back(expected_word(req_i.addr));
               read_count++;
               prev_rd = 1'b1;
            end
         end
      end
   end

   // limit grows with the traffic actually issued
   initial
   begin
      while (wd_cycles <= 200 + 4 * req_count)
      begin
         @(posedge clk_i);
         wd_cycles++;
      end
      $display("watchdog expired after %0d cycles, the tests did not finish", wd_cycles);
      $display("Finished with errors");
      $finish;
   end

   initial
   begin
      int       errs;
      sp_addr_t addr;
      sp_addr_t last_addr;
      logic [31:0] rnd;
      reset_i = 1'b1;
      req_i   = '0;
      repeat (4) @(posedge clk_i);
      reset_i <= 1'b0;

      // test 1 looks at the outputs after reset with no request
      errs = err_count;
      repeat (2)
      begin
         @(negedge clk_i);
         check_bit("rvalid_o", 1'b0, rvalid_o);
         check_word("rdata_o", '0, rdata_o);
      end
      report_test("reset", errs);

      // test 2 writes then reads back to back, three words in each bank
      errs = err_count;
      for (int i = 0; i < 6; i++)
      begin
         issue(1'b1, sp_addr_t'(i * 85 + 3), $random(seed));
      end
      for (int i = 0; i < 6; i++)
      begin
         issue(1'b0, sp_addr_t'(i * 85 + 3), '0);
      end
      issue(1'b1, 9'h003, $random(seed));
      issue(1'b1, 9'h102, $random(seed));
      issue(1'b0, 9'h003, '0);
      issue(1'b0, 9'h102, '0);
      drain();
      report_test("write_read", errs);

      // test 3 uses the same low address in both banks
      errs = err_count;
      for (int i = 0; i < 2; i++)
      begin
         rnd = $random(seed);
         addr = (i == 0) ? 9'h010 : 9'h077;
         issue(1'b1, addr, rnd);
         issue(1'b1, addr | 9'h100, ~rnd);
         issue(1'b0, addr, '0);
         issue(1'b0, addr | 9'h100, '0);
      end
      drain();
      report_test("isolation", errs);

      // test 4 checks that writes and idles after a read leave the output alone
      errs = err_count;
      issue(1'b0, 9'h058, '0);
      issue(1'b1, 9'h058, 32'hdead_beef);
      issue(1'b1, 9'h158, 32'h1234_5678);
      idle();
      idle();
      issue(1'b1, 9'h010, 32'h0f0f_0f0f);
      drain();
      repeat (2) idle();
      issue(1'b0, 9'h058, '0);
      drain();
      report_test("hold", errs);

      // test 5 fills every word and then runs random traffic
      errs = err_count;
      for (int i = 0; i < (1 << SP_AW); i++)
      begin
         issue(1'b1, sp_addr_t'(i), fill_pattern(sp_addr_t'(i)));
      end
      drain();
      read_count  = 0;
      pulse_count = 0;
      last_addr   = '0;
      for (int i = 0; i < 300; i++)
      begin
         rnd = $random(seed);
         addr = (rnd[3:1] < 3'd3) ? last_addr : rnd[12:4];
         issue(rnd[0], addr, $random(seed));
         last_addr = addr;
      end
      drain();
      if (read_count != pulse_count)
      begin
         $display("%0d reads issued but %0d read pulses seen", read_count, pulse_count);
         err_count++;
      end
      report_test("random", errs);

      $display("%0d requests issued, %0d errors", req_count, err_count);
      if (err_count == 0)
      begin
         $display("Finished with no errors");
      end
      else
      begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// File: files.f
+incdir+dv
hw/mem_pkg.sv
hw/mem_1r1w.sv
hw/mem_1rw_sync_synth.sv
hw/mem_1rw_sync.sv
hw/scratchpad_top.sv
dv/tb_scratchpad.sv

// File: hw/mem_1r1w.sv
// Two-port storage array with one write port and one read port.
// Writes land on the rising clock edge; the read port is combinational,
// so a register file or latch array can take its place without changes
// at the ports.

`timescale 1ns/10ps

module mem_1r1w
   import mem_pkg::*;
(
   input  logic       clk_i,

   // write port
   input  logic       w_v_i,
   input  bank_addr_t w_addr_i,
   input  word_t      w_data_i,

   // read port
   input  bank_addr_t r_addr_i,
   output word_t      r_data_o
);

   // storage, contents are undefined until written
   word_t mem_r [SP_BANK_ELS];

   always_ff @(posedge clk_i)
   begin
      if (w_v_i)
      begin
         mem_r[w_addr_i] <= w_data_i;
      end
   end

   // asynchronous read
   // a write to the same address shows up here only after the edge
   always_comb
   begin
      r_data_o = mem_r[r_addr_i];
   end

endmodule

// File: hw/mem_1rw_sync.sv
// Bank wrapper for a single-port synchronous RAM.
// substitute_1r1w_p = 1 builds the bank from a two-port array with an
// asynchronous read and an output register; 0 uses the synthesized RAM.
// Both give read data one cycle after the request and hold it otherwise.

`timescale 1ns/10ps

module mem_1rw_sync
   import mem_pkg::*;
#(
   parameter bit substitute_1r1w_p = 1'b1
)
(
   input  logic      clk_i,
   input  logic      reset_i,
   input  bank_req_t req_i,
   output word_t     data_o
);

   if (substitute_1r1w_p)
   begin : g_s1r1w

      logic  wr_v;
      logic  rd_v;
      word_t r_data_lo;

      assign wr_v = req_i.v & req_i.w;
      assign rd_v = req_i.v & ~req_i.w;

      // both ports share the one request address
      mem_1r1w u_mem
      (
         .clk_i    (clk_i),
         .w_v_i    (wr_v),
         .w_addr_i (req_i.addr),
         .w_data_i (req_i.data),
         .r_addr_i (req_i.addr),
         .r_data_o (r_data_lo)
      );

      // capture the async read at the edge that accepts the read,
      // which turns it into a one-cycle synchronous read
      always_ff @(posedge clk_i)
      begin
         if (reset_i)
         begin
            data_o <= '0;
         end
         else if (rd_v)
         begin
            data_o <= r_data_lo;
         end
      end

   end
   else
   begin : g_synth

      // the synthesized RAM already has the wanted timing
      mem_1rw_sync_synth u_mem
      (
         .clk_i   (clk_i),
         .reset_i (reset_i),
         .req_i   (req_i),
         .data_o  (data_o)
      );

   end

endmodule

// File: hw/mem_1rw_sync_synth.sv
// Single-port RAM with a registered read, written in the form that
// synthesis maps onto block RAM. One access per cycle, read or write.
// The read register loads only on a read and is cleared by reset.

`timescale 1ns/10ps

module mem_1rw_sync_synth
   import mem_pkg::*;
(
   input  logic      clk_i,
   input  logic      reset_i,
   input  bank_req_t req_i,
   output word_t     data_o
);

   word_t mem_r [SP_BANK_ELS];
   logic  wr_en;
   logic  rd_en;

   // decode the strobes once
   assign wr_en = req_i.v & req_i.w;
   assign rd_en = req_i.v & ~req_i.w;

   // write side of the array
   always_ff @(posedge clk_i)
   begin
      if (wr_en)
      begin
         mem_r[req_i.addr] <= req_i.data;
      end
   end

   // output register of the RAM block
   // keeps the last read word while the port writes or idles
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         data_o <= '0;
      end
      else if (rd_en)
      begin
         data_o <= mem_r[req_i.addr];
      end
   end

endmodule

// File: hw/mem_pkg.sv
// Shared sizes, word and address types, and request structs for the
// two-bank scratchpad. Every RTL module imports this package in its header.

package mem_pkg;

   // data word width in bits
   localparam int SP_WIDTH = 32;

   // words held by each bank
   localparam int SP_BANK_ELS = 256;

   // word address width inside one bank
   localparam int SP_BANK_AW = $clog2(SP_BANK_ELS);

   // scratchpad address width, the top bit selects the bank
   localparam int SP_AW = SP_BANK_AW + 1;

   typedef logic [SP_WIDTH-1:0]   word_t;
   typedef logic [SP_BANK_AW-1:0] bank_addr_t;
   typedef logic [SP_AW-1:0]      sp_addr_t;

   // one request as seen by a single bank
   typedef struct packed {
      logic       v;
      logic       w;
      bank_addr_t addr;
      word_t      data;
   } bank_req_t;

   // one request as seen at the scratchpad boundary
   typedef struct packed {
      logic     v;
      logic     w;
      sp_addr_t addr;
      word_t    data;
   } sp_req_t;

endpackage

// File: hw/scratchpad_top.sv
// Two-bank scratchpad of 512 words, one read or write per cycle.
// The top address bit picks the bank. Read data comes back on rdata_o
// one cycle after the request with a single-cycle rvalid_o pulse, and
// rdata_o holds until the next read completes.

`timescale 1ns/10ps

module scratchpad_top
   import mem_pkg::*;
(
   input  logic    clk_i,
   input  logic    reset_i,
   input  sp_req_t req_i,
   output word_t   rdata_o,
   output logic    rvalid_o
);

   logic       bank_sel;
   bank_addr_t bank_addr;
   logic       rd_accept;

   bank_req_t  bank0_req;
   bank_req_t  bank1_req;
   word_t      bank0_data;
   word_t      bank1_data;

   // bank of the read in flight, and its valid pulse
   logic       rd_bank_r;
   logic       rvalid_r;

   assign bank_sel  = req_i.addr[SP_AW-1];
   assign bank_addr = req_i.addr[SP_BANK_AW-1:0];
   assign rd_accept = req_i.v & ~req_i.w;

   // fan the request out, only the selected bank sees v high
   always_comb
   begin
      bank0_req.v    = req_i.v & ~bank_sel;
      bank0_req.w    = req_i.w;
      bank0_req.addr = bank_addr;
      bank0_req.data = req_i.data;

      bank1_req.v    = req_i.v & bank_sel;
      bank1_req.w    = req_i.w;
      bank1_req.addr = bank_addr;
      bank1_req.data = req_i.data;
   end

   // bank 0 on the two-port substitute
   mem_1rw_sync #(.substitute_1r1w_p(1'b1)) u_bank0
   (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (bank0_req),
      .data_o  (bank0_data)
   );

   // bank 1 on the synthesized single-port RAM
   mem_1rw_sync #(.substitute_1r1w_p(1'b0)) u_bank1
   (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (bank1_req),
      .data_o  (bank1_data)
   );

   // remember which bank answers the read
   // rd_bank_r only moves on a read so the mux below keeps pointing at
   // the bank that holds the last read word
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         rvalid_r  <= 1'b0;
         rd_bank_r <= 1'b0;
      end
      else
      begin
         rvalid_r <= rd_accept;
         if (rd_accept)
         begin
            rd_bank_r <= bank_sel;
         end
      end
   end

   // steer the returning word, each bank holds its own output
   assign rdata_o  = rd_bank_r ? bank1_data : bank0_data;
   assign rvalid_o = rvalid_r;

endmodule

// File: run.sh
#!/bin/sh
# Build the scratchpad testbench with Verilator, run it, and scan the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --top-module tb_scratchpad -f files.f \
   > build.log 2>&1 \
   && ./obj_dir/Vtb_scratchpad > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "build or run did not complete"; exit 1; }

cat sim.log
grep -q "Finished with errors" sim.log \
   && { echo "simulation FAILED"; exit 1; }

echo "simulation passed"
exit 0
